// File: runSim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module storeBackendTb -f storeBackendTop.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/VstoreBackendTb > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

// File: src/evictBuffer.sv
`timescale 1ns/10ps

module evictBuffer import storePkg::*; #(
    parameter int numEvicted = defaultNumEvicted
) (
    input logic clk,
    input logic rst,
    input FusedEntry fused,
    output logic insertTaken,
    input logic storesPending,
    output logic busy,
    output FusedEntry entries [numEvicted],
    output StUop stUop,
    input logic stStall,
    input StAck stAck
);

    logic issued [numEvicted];
    StNonce nonce [numEvicted];

    logic mmioPending;
    logic slotFound;
    StId slotIdx;
    logic reissueFound;
    StId reissueIdx;

    FusedEntry newEntry;
    StNonce newNonce;
    StAck ackReg;

    function automatic StUop buildUop(input FusedEntry e, input StId id, input StNonce n);
        StUop u;
        u.valid = 1'b1;
        u.id = id;
        u.nonce = n;
        u.addr = {e.lineAddr, e.word, 2'b00};
        u.data = e.data;
        u.wmask = e.wmask;
        u.isMmio = isMmioAddr(lineBase(e));
        return u;
    endfunction

    // Slot choice: same line wins, else lowest free entry
    always_comb begin
        mmioPending = 1'b0;
        slotFound = 1'b0;
        slotIdx = '0;
        for (int i = 0; i < numEvicted; i++) begin
            if (entries[i].valid && isMmioAddr(lineBase(entries[i]))) begin
                mmioPending = 1'b1;
            end
            if (!entries[i].valid && !slotFound) begin
                slotFound = 1'b1;
                slotIdx = StId'(i);
            end
        end
        for (int i = 0; i < numEvicted; i++) begin
            if (entries[i].valid && entries[i].lineAddr == fused.lineAddr) begin
                slotFound = 1'b1;
                slotIdx = StId'(i);
            end
        end
        // Only one device write in flight
        insertTaken = fused.valid && slotFound &&
            !(mmioPending && isMmioAddr(lineBase(fused)));
    end

    always_comb begin
        reissueFound = 1'b0;
        reissueIdx = '0;
        for (int i = numEvicted - 1; i >= 0; i--) begin
            if (entries[i].valid && !issued[i]) begin
                reissueFound = 1'b1;
                reissueIdx = StId'(i);
            end
        end
    end

    // Merge the fused write over whatever the slot already holds
    always_comb begin
        newEntry = fused;
        newEntry.valid = 1'b1;
        newEntry.wmask = fused.wmask |
            (entries[slotIdx].valid ? entries[slotIdx].wmask : '0);
        for (int b = 0; b < lineBytes; b++) begin
            if (!fused.wmask[b]) begin
                newEntry.data[b*8 +: 8] = entries[slotIdx].data[b*8 +: 8];
            end
        end
        newNonce = nonce[slotIdx] + 1'b1;
    end

    always_comb begin
        busy = fused.valid || storesPending;
        for (int i = 0; i < numEvicted; i++) begin
            if (entries[i].valid) begin
                busy = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numEvicted; i++) begin
                entries[i].valid <= 1'b0;
                issued[i] <= 1'b0;
                nonce[i] <= '0;
            end
            stUop.valid <= 1'b0;
            ackReg.valid <= 1'b0;
        end
        else begin
            stUop.valid <= 1'b0;
            ackReg <= stAck;

            // Refused by memory, try again later
            if (stUop.valid && stStall) begin
                issued[stUop.id] <= 1'b0;
            end

            if (ackReg.valid && entries[ackReg.id].valid &&
                ackReg.nonce == nonce[ackReg.id]) begin
                issued[ackReg.id] <= 1'b0;
                if (!ackReg.fail) begin
                    entries[ackReg.id].valid <= 1'b0;
                end
            end

            if (reissueFound) begin
                issued[reissueIdx] <= 1'b1;
                stUop <= buildUop(entries[reissueIdx], reissueIdx, nonce[reissueIdx]);
            end

            if (insertTaken) begin
                entries[slotIdx] <= newEntry;
                nonce[slotIdx] <= newNonce;
                issued[slotIdx] <= !reissueFound;
                if (!reissueFound) begin
                    stUop <= buildUop(newEntry, slotIdx, newNonce);
                end
            end
        end
    end

endmodule

// File: src/storeBackendTop.sv
`timescale 1ns/10ps

module storeBackendTop import storePkg::*; #(
    parameter int numIn = defaultNumIn,
    parameter int numEvicted = defaultNumEvicted,
    parameter int numLoads = defaultNumLoads
) (
    input logic clk,
    input logic rst,
    input SqUop stores [numIn],
    output logic stall [numIn],
    input LoadReq loads [numLoads],
    output FwdResult fwd [numLoads],
    output StUop stUop,
    input logic stStall,
    input StAck stAck,
    output logic busy
);

    FusedEntry fused;
    FusedEntry entries [numEvicted];
    logic insertTaken;
    logic storesPending;

    always_comb begin
        storesPending = 1'b0;
        for (int i = 0; i < numIn; i++) begin
            storesPending = storesPending | stores[i].valid;
        end
    end

    storeFuser #(.numIn(numIn)) fuser (
        .clk(clk),
        .rst(rst),
        .stores(stores),
        .stall(stall),
        .insertTaken(insertTaken),
        .fused(fused)
    );

    evictBuffer #(.numEvicted(numEvicted)) evict (
        .clk(clk),
        .rst(rst),
        .fused(fused),
        .insertTaken(insertTaken),
        .storesPending(storesPending),
        .busy(busy),
        .entries(entries),
        .stUop(stUop),
        .stStall(stStall),
        .stAck(stAck)
    );

    storeForward #(.numEvicted(numEvicted), .numLoads(numLoads)) forward (
        .clk(clk),
        .rst(rst),
        .loads(loads),
        .entries(entries),
        .fused(fused),
        .fwd(fwd)
    );

endmodule

// File: src/storeForward.sv
`timescale 1ns/10ps

module storeForward import storePkg::*; #(
    parameter int numEvicted = defaultNumEvicted,
    parameter int numLoads = defaultNumLoads
) (
    input logic clk,
    input logic rst,
    input LoadReq loads [numLoads],
    input FusedEntry entries [numEvicted],
    input FusedEntry fused,
    output FwdResult fwd [numLoads]
);

    FusedEntry sources [numEvicted+1];
    logic [31:0] hitData [numLoads];
    logic [3:0] hitMask [numLoads];

    // Oldest first, the fused register is the youngest
    always_comb begin
        for (int i = 0; i < numEvicted; i++) begin
            sources[i] = entries[i];
        end
        sources[numEvicted] = fused;
    end

    always_comb begin
        logic [31:0] wordData;
        logic [3:0] wordMask;

        for (int h = 0; h < numLoads; h++) begin
            hitData[h] = '0;
            hitMask[h] = '0;
            for (int i = 0; i <= numEvicted; i++) begin
                wordData = sources[i].data[{loads[h].addr[offsetBits-1:2], 5'b0} +: 32];
                wordMask = sources[i].wmask[{loads[h].addr[offsetBits-1:2], 2'b0} +: 4];
                if (sources[i].valid && !isMmioAddr(lineBase(sources[i])) &&
                    sources[i].lineAddr == loads[h].addr[31:offsetBits]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wordMask[b]) begin
                            hitData[h][b*8 +: 8] = wordData[b*8 +: 8];
                        end
                    end
                    hitMask[h] = hitMask[h] | wordMask;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int h = 0; h < numLoads; h++) begin
            fwd[h].data <= hitData[h];
            fwd[h].mask <= hitMask[h];
            if (rst) begin
                fwd[h].valid <= 1'b0;
            end
            else begin
                fwd[h].valid <= loads[h].valid;
            end
        end
    end

endmodule

// File: src/storeFuser.sv
`timescale 1ns/10ps

module storeFuser import storePkg::*; #(
    parameter int numIn = defaultNumIn
) (
    input logic clk,
    input logic rst,
    input SqUop stores [numIn],
    output logic stall [numIn],
    input logic insertTaken,
    output FusedEntry fused
);

    FusedEntry fusedNext;
    logic canTake;

    always_comb begin
        int byteIdx;

        fusedNext = fused;
        byteIdx = 0;
        if (insertTaken) begin
            fusedNext.valid = 1'b0;
        end

        for (int i = 0; i < numIn; i++) begin
            stall[i] = 1'b1;
        end

        // The register is free, or drains into the buffer this cycle
        canTake = !fused.valid || insertTaken;

        if (canTake && stores[0].valid) begin
            stall[0] = 1'b0;
            fusedNext.valid = 1'b1;
            fusedNext.lineAddr = stores[0].addr[31:offsetBits];

            if (isMmioAddr(stores[0].addr)) begin
                // Device writes keep their word unshifted
                fusedNext.word = stores[0].addr[offsetBits-1:2];
                fusedNext.data = (lineBytes*8)'(stores[0].data);
                fusedNext.wmask = lineBytes'(stores[0].wmask);
            end
            else begin
                fusedNext.word = '0;
                fusedNext.data = (lineBytes*8)'(stores[0].data)
                    << {stores[0].addr[offsetBits-1:2], 5'b0};
                fusedNext.wmask = lineBytes'(stores[0].wmask)
                    << {stores[0].addr[offsetBits-1:2], 2'b0};

                // Fold in younger stores to the same line
                for (int i = 1; i < numIn; i++) begin
                    if (stores[i].valid && !isMmioAddr(stores[i].addr) &&
                        stores[i].addr[31:offsetBits] == fusedNext.lineAddr) begin
                        stall[i] = 1'b0;
                        for (int b = 0; b < 4; b++) begin
                            if (stores[i].wmask[b]) begin
                                byteIdx = stores[i].addr[offsetBits-1:2] * 4 + b;
                                fusedNext.data[byteIdx*8 +: 8] = stores[i].data[b*8 +: 8];
                                fusedNext.wmask[byteIdx] = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        fused <= fusedNext;
        if (rst) begin
            fused.valid <= 1'b0;
        end
    end

endmodule

// File: src/storePkg.sv
package storePkg;

    // Line geometry
    localparam int lineBytes = 16;
    localparam int lineWords = 4;
    localparam int offsetBits = $clog2(lineBytes);
    localparam int wordBits = $clog2(lineWords);
    localparam int lineAddrBits = 32 - offsetBits;

    // Parameter defaults for the top level
    localparam int defaultNumIn = 2;
    localparam int defaultNumEvicted = 4;
    localparam int defaultNumLoads = 2;

    localparam int stIdBits = $clog2(defaultNumEvicted);

    typedef logic [1:0] StNonce;
    typedef logic [stIdBits-1:0] StId;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } SqUop;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
    } LoadReq;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        logic [3:0] mask;
    } FwdResult;

    // One line-sized write, word is only meaningful for MMIO
    typedef struct packed {
        logic valid;
        logic [lineAddrBits-1:0] lineAddr;
        logic [wordBits-1:0] word;
        logic [lineBytes*8-1:0] data;
        logic [lineBytes-1:0] wmask;
    } FusedEntry;

    typedef struct packed {
        logic valid;
        StId id;
        StNonce nonce;
        logic [31:0] addr;
        logic [lineBytes*8-1:0] data;
        logic [lineBytes-1:0] wmask;
        logic isMmio;
    } StUop;

    typedef struct packed {
        logic valid;
        StId id;
        StNonce nonce;
        logic fail;
    } StAck;

    // Uncached device region
    function automatic logic isMmioAddr(input logic [31:0] addr);
        return addr[31];
    endfunction

    function automatic logic [31:0] lineBase(input FusedEntry e);
        return {e.lineAddr, {offsetBits{1'b0}}};
    endfunction

endpackage

// File: storeBackendTop.f
src/storePkg.sv
src/storeFuser.sv
src/evictBuffer.sv
src/storeForward.sv
src/storeBackendTop.sv
verification/storeBackend_checker.sv
verification/storeBackendTb.sv

// File: verification/storeBackendTb.sv
`timescale 1ns/10ps

module storeBackendTb import storePkg::*;;

    localparam int numRows = 31;
    localparam int cycleLimit = 2 * numRows + 20;

    logic clk;
    logic rst;
    SqUop stores [2];
    logic stall [2];
    LoadReq loads [2];
    FwdResult fwd [2];
    StUop stUop;
    logic stStall;
    StAck stAck;
    logic busy;

    // Stimulus and expected values, one row per cycle
    SqUop rowStores [numRows][2];
    logic [1:0] rowStallCare [numRows];
    logic [1:0] rowStallExp [numRows];
    LoadReq rowLoads [numRows][2];
    logic rowStStall [numRows];
    StAck rowAck [numRows];
    StUop rowUop [numRows];
    FwdResult rowFwd [numRows][2];
    logic rowBusy [numRows];
    logic [31:0] d [9];
    logic [31:0] ef;
    logic [31:0] seed;
    int cycles;

    storeBackendTop #(.numIn(2), .numEvicted(4), .numLoads(2)) uut (
        .clk(clk), .rst(rst), .stores(stores), .stall(stall), .loads(loads), .fwd(fwd),
        .stUop(stUop), .stStall(stStall), .stAck(stAck), .busy(busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One byte enable widened to eight data bits
    function automatic logic [127:0] byteMask(input logic [15:0] m);
        logic [127:0] r;
        for (int b = 0; b < 16; b++) begin
            r[b*8 +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    task automatic putStore(input int r, input int lane, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask, input logic st);
        rowStores[r][lane] = '{1'b1, addr, data, mask};
        rowStallCare[r][lane] = 1'b1;
        rowStallExp[r][lane] = st;
    endtask

    // The forward result is expected in the following row
    task automatic putLoad(input int r, input int lane, input logic [31:0] addr,
                           input logic [31:0] expData, input logic [3:0] expMask);
        rowLoads[r][lane] = '{1'b1, addr};
        rowFwd[r+1][lane] = '{1'b1, expData, expMask};
    endtask

    task automatic putUop(input int r, input int id, input int n, input logic [31:0] addr,
                          input logic [127:0] data, input logic [15:0] wmask, input logic mmio);
        rowUop[r] = '{1'b1, StId'(id), StNonce'(n), addr, data, wmask, mmio};
    endtask

    task automatic putAck(input int r, input int id, input int n, input logic fail);
        rowAck[r] = '{1'b1, StId'(id), StNonce'(n), fail};
    endtask

    task automatic checkEq(input string name, input logic [127:0] got, input logic [127:0] exp);
        assert (got === exp)
        else begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic checkRow(input int r);
        for (int i = 0; i < 2; i++) begin
            if (rowStallCare[r][i]) begin
                checkEq($sformatf("stall[%0d]", i), stall[i], rowStallExp[r][i]);
            end
            checkEq($sformatf("fwd[%0d].valid", i), fwd[i].valid, rowFwd[r][i].valid);
            if (rowFwd[r][i].valid) begin
                checkEq($sformatf("fwd[%0d].mask", i), fwd[i].mask, rowFwd[r][i].mask);
                checkEq($sformatf("fwd[%0d].data", i), fwd[i].data & byteMask(16'(fwd[i].mask)),
                        rowFwd[r][i].data & byteMask(16'(rowFwd[r][i].mask)));
            end
        end
        checkEq("stUop.valid", stUop.valid, rowUop[r].valid);
        if (rowUop[r].valid) begin
            checkEq("stUop.id", stUop.id, rowUop[r].id);
            checkEq("stUop.nonce", stUop.nonce, rowUop[r].nonce);
            checkEq("stUop.addr", stUop.addr, rowUop[r].addr);
            checkEq("stUop.wmask", stUop.wmask, rowUop[r].wmask);
            checkEq("stUop.isMmio", stUop.isMmio, rowUop[r].isMmio);
            checkEq("stUop.data", stUop.data & byteMask(rowUop[r].wmask),
                    rowUop[r].data & byteMask(rowUop[r].wmask));
        end
        checkEq("busy", busy, rowBusy[r]);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cycles = 0;
        stStall = 1'b0;
        stAck = '0;
        for (int i = 0; i < 2; i++) begin
            stores[i] = '0;
            loads[i] = '0;
        end
        seed = 32'h161e776f;
        for (int k = 0; k < 9; k++) begin
            seed = xorshift(seed);
            d[k] = seed;
        end
        ef = {d[4][31:16], d[5][15:0]};
        for (int r = 0; r < numRows; r++) begin
            rowStores[r] = '{default: '0};
            rowLoads[r] = '{default: '0};
            rowFwd[r] = '{default: '0};
            rowStallCare[r] = '0;
            rowStallExp[r] = '0;
            rowStStall[r] = 1'b0;
            rowAck[r] = '0;
            rowUop[r] = '0;
            rowBusy[r] = !(r == 0 || r == 13 || r == 20 || r == 30);
        end

        // Same-line pair, then a lane to another line that stalls
        putStore(1, 0, 32'h1000, d[0], 4'hF, 1'b0);
        putStore(1, 1, 32'h1004, d[1], 4'hF, 1'b0);
        putStore(2, 0, 32'h2008, d[2], 4'h3, 1'b0);
        putStore(2, 1, 32'h3000, d[3], 4'hF, 1'b1);
        putLoad(2, 0, 32'h1004, d[1], 4'hF);
        putStore(3, 0, 32'h3000, d[3], 4'hF, 1'b0);
        rowStStall[3] = 1'b1;
        putUop(3, 0, 1, 32'h1000, {64'h0, d[1], d[0]}, 16'h00FF, 1'b0);
        putLoad(3, 0, 32'h1000, d[0], 4'hF);
        putLoad(3, 1, 32'h8000_0010, 32'h0, 4'h0);
        putUop(4, 1, 1, 32'h2000, {32'h0, d[2], 64'h0}, 16'h0300, 1'b0);
        putUop(5, 0, 1, 32'h1000, {64'h0, d[1], d[0]}, 16'h00FF, 1'b0);
        putUop(6, 2, 1, 32'h3000, {96'h0, d[3]}, 16'h000F, 1'b0);
        // Failed ack, then a stale one
        putAck(6, 0, 1, 1'b1);
        putAck(7, 1, 2, 1'b0);
        putLoad(8, 0, 32'h1000, d[0], 4'hF);
        putUop(9, 0, 1, 32'h1000, {64'h0, d[1], d[0]}, 16'h00FF, 1'b0);
        putLoad(9, 0, 32'h2008, {16'h0, d[2][15:0]}, 4'h3);
        putAck(9, 0, 1, 1'b0);
        putAck(10, 1, 1, 1'b0);
        putAck(11, 2, 1, 1'b0);
        putLoad(12, 0, 32'h1000, 32'h0, 4'h0);
        // Younger partial write over an entry of the same line
        putStore(14, 0, 32'h1000, d[4], 4'hF, 1'b0);
        putStore(15, 0, 32'h1000, d[5], 4'h3, 1'b0);
        putUop(16, 0, 2, 32'h1000, {96'h0, d[4]}, 16'h000F, 1'b0);
        putLoad(16, 0, 32'h1000, ef, 4'hF);
        putUop(17, 0, 3, 32'h1000, {96'h0, ef}, 16'h000F, 1'b0);
        putAck(17, 0, 2, 1'b0);
        putAck(18, 0, 3, 1'b0);
        putLoad(19, 0, 32'h1000, ef, 4'hF);
        // Two device writes and a normal store held behind them
        putStore(21, 0, 32'h8000_0010, d[6], 4'hF, 1'b0);
        putStore(21, 1, 32'h8000_0024, d[7], 4'hF, 1'b1);
        putStore(22, 0, 32'h8000_0024, d[7], 4'hF, 1'b0);
        putUop(23, 0, 0, 32'h8000_0010, {96'h0, d[6]}, 16'h000F, 1'b1);
        putLoad(23, 1, 32'h8000_0010, 32'h0, 4'h0);
        putStore(24, 0, 32'h4000, d[8], 4'hF, 1'b1);
        putAck(24, 0, 0, 1'b0);
        putStore(25, 0, 32'h4000, d[8], 4'hF, 1'b1);
        putStore(26, 0, 32'h4000, d[8], 4'hF, 1'b0);
        putUop(27, 0, 1, 32'h8000_0024, {96'h0, d[7]}, 16'h000F, 1'b1);
        putAck(27, 0, 1, 1'b0);
        putUop(28, 1, 2, 32'h4000, {96'h0, d[8]}, 16'h000F, 1'b0);
        putAck(28, 1, 2, 1'b0);

        repeat (3) @(posedge clk);
        for (int r = 0; r < numRows; r++) begin
            #1;
            rst = 1'b0;
            stores = rowStores[r];
            loads = rowLoads[r];
            stStall = rowStStall[r];
            stAck = rowAck[r];
            #8;
            checkRow(r);
            @(posedge clk);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verification/storeBackend_checker.sv
`timescale 1ns/10ps

module storeBackendChecker import storePkg::*; (
    input logic clk,
    input logic rst,
    input StUop stUop,
    input FusedEntry fused,
    input logic lane0Valid,
    input logic lane0Stall,
    input logic busy
);

    // A write is presented for one cycle only
    oneCycleUop: assert property (@(posedge clk) disable iff (rst)
        (stUop.valid && $past(stUop.valid)) |->
            ({stUop.id, stUop.nonce} != {$past(stUop.id), $past(stUop.nonce)}))
    else $error("stUop held the same write for two cycles");

    // An empty fused register always takes the oldest lane
    lane0Free: assert property (@(posedge clk) disable iff (rst)
        (!fused.valid && lane0Valid) |-> !lane0Stall)
    else $error("lane 0 stalled while the fused register was empty");

    busyOnIssue: assert property (@(posedge clk) disable iff (rst)
        stUop.valid |-> busy)
    else $error("busy low while a store was issued");

endmodule

bind storeBackendTop storeBackendChecker backendChecker (
    .clk(clk),
    .rst(rst),
    .stUop(stUop),
    .fused(fused),
    .lane0Valid(stores[0].valid),
    .lane0Stall(stall[0]),
    .busy(busy)
);
